// ==== verilog/alloc_pkg.sv ====
package alloc_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    // Descriptor memory holds 2**PTR_WID entries
    localparam int PTR_WID  = 6;
    localparam int SIZE_WID = 8;
    localparam int META_WID = 4;

    typedef logic [PTR_WID-1:0]  ptr_t;
    typedef logic [SIZE_WID-1:0] size_t;
    typedef logic [META_WID-1:0] meta_t;

    // ----------------------------------------
    // Descriptor and per-buffer result
    // ----------------------------------------

    // Descriptor as stored in memory, 20 bits
    typedef struct packed {
        ptr_t  nxt_ptr;
        logic  eof;
        size_t size;
        meta_t meta;
        logic  err;
    } desc_t;

    // Per-buffer result handed back to a context
    // ptr is the address the descriptor was read from
    typedef struct packed {
        ptr_t  ptr;
        logic  eof;
        size_t size;
        meta_t meta;
        logic  err;
    } buf_info_t;

endpackage : alloc_pkg

// ==== verilog/gather_pkg.sv ====
package gather_pkg;

    // ----------------------------------------
    // Gather context handshakes
    // ----------------------------------------

    // Head pointer of a chain, held until accepted
    typedef struct packed {
        logic            vld;
        alloc_pkg::ptr_t ptr;
    } gather_req_t;

    // One buffer of the chain, vld marks a FIFO entry
    typedef struct packed {
        logic                 vld;
        alloc_pkg::buf_info_t info;
    } gather_resp_t;

    // ----------------------------------------
    // Descriptor memory write
    // ----------------------------------------

    // No ready, ignored until the clearing sweep is over
    typedef struct packed {
        logic             vld;
        alloc_pkg::ptr_t  addr;
        alloc_pkg::desc_t desc;
    } desc_wr_t;

endpackage : gather_pkg

// ==== verilog/fifo_ctxt.sv ====
`timescale 1ns/1ps

module fifo_ctxt #(
    parameter int DEPTH    = 4,
    parameter int DATA_WID = 8
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                wr,
    input  logic [DATA_WID-1:0] wr_data,
    output logic                wr_rdy,
    input  logic                rd,
    output logic                rd_vld,
    output logic [DATA_WID-1:0] rd_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [DATA_WID-1:0] mem [DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [CW-1:0]       count;
    logic                push;
    logic                pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        if (int'(p) == DEPTH - 1) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign wr_rdy = (count < CW'(DEPTH));
    assign rd_vld = (count != '0);
    assign push   = wr && wr_rdy;
    assign pop    = rd && rd_vld;

    // Head is visible without a read strobe
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : fifo_ctxt

// ==== verilog/arb_rr.sv ====
`timescale 1ns/1ps

module arb_rr #(
    parameter int N = 2
) (
    input  logic                                clk,
    input  logic                                srst,
    input  logic                                en,
    input  logic [N-1:0]                        req,
    output logic [N-1:0]                        grant,
    output logic [$clog2((N > 1) ? N : 2)-1:0] sel
);

    localparam int SEL_WID = $clog2((N > 1) ? N : 2);

    logic [SEL_WID-1:0] prio;
    logic [SEL_WID-1:0] win;
    logic               found;

    // ----------------------------------------
    // First requester at or after prio
    // ----------------------------------------
    always_comb begin
        int idx;
        found = 1'b0;
        win   = '0;
        for (int i = 0; i < N; i++) begin
            idx = (int'(prio) + i) % N;
            if (!found && req[idx]) begin
                found = 1'b1;
                win   = SEL_WID'(idx);
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[win] = 1'b1;
        end
    end

    assign sel = win;

    // Winner drops to lowest priority, idle cycles keep the pointer
    always_ff @(posedge clk) begin
        if (srst) begin
            prio <= '0;
        end else if (en && found) begin
            prio <= (int'(win) == N - 1) ? '0 : win + 1'b1;
        end
    end

endmodule : arb_rr

// ==== verilog/desc_mem.sv ====
`timescale 1ns/1ps

module desc_mem #(
    parameter int DEPTH = 64
) (
    input  logic                 clk,
    input  logic                 srst,
    input  gather_pkg::desc_wr_t wr,
    input  logic                 rd_req,
    output logic                 rd_rdy,
    input  alloc_pkg::ptr_t      rd_addr,
    output logic                 rd_ack,
    output alloc_pkg::desc_t     rd_data,
    output logic                 init_done
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    alloc_pkg::desc_t mem [DEPTH];
    logic [AW-1:0]    init_cnt;
    logic             rd_go;

    // ----------------------------------------
    // Clearing sweep
    // ----------------------------------------
    // One entry per cycle, init_done after exactly DEPTH cycles
    always_ff @(posedge clk) begin
        if (srst) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_cnt <= init_cnt + 1'b1;
            if (int'(init_cnt) == DEPTH - 1) begin
                init_done <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    // Sweep owns the array until done, then the write port
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_cnt] <= '0;
        end else if (wr.vld) begin
            mem[wr.addr] <= wr.desc;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------
    assign rd_rdy = init_done;
    assign rd_go  = rd_req && rd_rdy;

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_go;
        end
    end

    // Old contents on a same-cycle write to the read address
    always_ff @(posedge clk) begin
        if (rd_go) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : desc_mem

// ==== verilog/alloc_gather_core.sv ====
`timescale 1ns/1ps

module alloc_gather_core #(
    parameter int CONTEXTS = 2,
    parameter int Q_DEPTH  = 4
) (
    input  logic                     clk,
    input  logic                     srst,
    input  logic                     en,
    input  gather_pkg::gather_req_t  gather_req [CONTEXTS],
    output logic [CONTEXTS-1:0]      gather_rdy,
    output gather_pkg::gather_resp_t gather_resp [CONTEXTS],
    input  logic [CONTEXTS-1:0]      gather_ack,
    output logic                     dealloc_req,
    input  logic                     dealloc_rdy,
    output alloc_pkg::ptr_t          dealloc_ptr,
    output logic                     rd_req,
    input  logic                     rd_rdy,
    output alloc_pkg::ptr_t          rd_addr,
    input  logic                     rd_ack,
    input  alloc_pkg::desc_t         rd_data,
    input  logic                     init_done
);

    localparam int CTXT_WID = $clog2((CONTEXTS > 1) ? CONTEXTS : 2);
    localparam int RQ_DEPTH = 2;
    localparam int DQ_DEPTH = 4;

    typedef logic [CTXT_WID-1:0] ctxt_id_t;

    typedef enum logic [1:0] {
        RESET,
        DISABLED,
        IDLE,
        READ
    } state_t;

    // Travels with each read so the ack finds its context
    typedef struct packed {
        ctxt_id_t        id;
        alloc_pkg::ptr_t ptr;
    } rd_ctxt_t;

    state_t state;
    state_t nxt_state;

    logic [CONTEXTS-1:0] resp_space;
    logic [CONTEXTS-1:0] arb_req;
    logic [CONTEXTS-1:0] arb_grant;
    ctxt_id_t            arb_sel;
    alloc_pkg::ptr_t     ctxt_ptr [CONTEXTS];

    logic     arb_en;
    logic     take;
    logic     issue;
    logic     dq_space;
    logic     rq_vld;
    rd_ctxt_t rd_ctxt_in;
    rd_ctxt_t rd_ctxt_out;

    // ----------------------------------------
    // Chain walkers
    // ----------------------------------------
    for (genvar c = 0; c < CONTEXTS; c++) begin : g_ctxt
        logic                 busy;
        logic                 pend;
        logic                 accept;
        logic                 rd_done;
        alloc_pkg::ptr_t      nxt_ptr;
        alloc_pkg::buf_info_t info_in;

        assign gather_rdy[c] = init_done && !busy;
        assign accept        = gather_req[c].vld && gather_rdy[c];
        assign rd_done       = rd_ack && rq_vld && (rd_ctxt_out.id == ctxt_id_t'(c));

        // Ask only when the response FIFO can take the result
        assign arb_req[c]  = pend && resp_space[c];
        assign ctxt_ptr[c] = nxt_ptr;

        always_ff @(posedge clk) begin
            if (srst) begin
                busy <= 1'b0;
                pend <= 1'b0;
            end else begin
                if (accept) begin
                    busy <= 1'b1;
                end else if (rd_done && rd_data.eof) begin
                    busy <= 1'b0;
                end
                if (accept || (rd_done && !rd_data.eof)) begin
                    pend <= 1'b1;
                end else if (take && arb_grant[c]) begin
                    pend <= 1'b0;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (accept) begin
                nxt_ptr <= gather_req[c].ptr;
            end else if (rd_done) begin
                nxt_ptr <= rd_data.nxt_ptr;
            end
        end

        assign info_in = '{
            ptr:  rd_ctxt_out.ptr,
            eof:  rd_data.eof,
            size: rd_data.size,
            meta: rd_data.meta,
            err:  rd_data.err
        };

        fifo_ctxt #(
            .DEPTH    (Q_DEPTH),
            .DATA_WID ($bits(alloc_pkg::buf_info_t))
        ) u_resp_fifo (
            .clk     (clk),
            .srst    (srst),
            .wr      (rd_done),
            .wr_data (info_in),
            .wr_rdy  (resp_space[c]),
            .rd      (gather_ack[c]),
            .rd_vld  (gather_resp[c].vld),
            .rd_data (gather_resp[c].info)
        );
    end

    // ----------------------------------------
    // Read FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        arb_en    = 1'b0;
        rd_req    = 1'b0;
        case (state)
            RESET: begin
                if (init_done) begin
                    nxt_state = en ? IDLE : DISABLED;
                end
            end
            DISABLED: begin
                if (en) begin
                    nxt_state = IDLE;
                end
            end
            IDLE: begin
                if (!en) begin
                    nxt_state = DISABLED;
                end else if (dq_space) begin
                    arb_en = 1'b1;
                    if (|arb_req) begin
                        nxt_state = READ;
                    end
                end
            end
            READ: begin
                rd_req = 1'b1;
                if (rd_rdy) begin
                    nxt_state = IDLE;
                end
            end
            default: nxt_state = RESET;
        endcase
    end

    assign take  = arb_en && (|arb_req);
    assign issue = rd_req && rd_rdy;

    arb_rr #(
        .N (CONTEXTS)
    ) u_arb (
        .clk   (clk),
        .srst  (srst),
        .en    (arb_en),
        .req   (arb_req),
        .grant (arb_grant),
        .sel   (arb_sel)
    );

    // Winner latched in IDLE, read issued from it in READ
    always_ff @(posedge clk) begin
        if (take) begin
            rd_ctxt_in.id  <= arb_sel;
            rd_ctxt_in.ptr <= ctxt_ptr[arb_sel];
        end
    end

    assign rd_addr = rd_ctxt_in.ptr;

    fifo_ctxt #(
        .DEPTH    (RQ_DEPTH),
        .DATA_WID ($bits(rd_ctxt_t))
    ) u_rd_ctxt_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (issue),
        .wr_data (rd_ctxt_in),
        .wr_rdy  (),
        .rd      (rd_ack),
        .rd_vld  (rq_vld),
        .rd_data (rd_ctxt_out)
    );

    // ----------------------------------------
    // Deallocation
    // ----------------------------------------
    // Pointer queued at issue so the IDLE space check is exact
    fifo_ctxt #(
        .DEPTH    (DQ_DEPTH),
        .DATA_WID (alloc_pkg::PTR_WID)
    ) u_dealloc_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (issue),
        .wr_data (rd_ctxt_in.ptr),
        .wr_rdy  (dq_space),
        .rd      (dealloc_rdy),
        .rd_vld  (dealloc_req),
        .rd_data (dealloc_ptr)
    );

endmodule : alloc_gather_core

// ==== verilog/alloc_gather_top.sv ====
`timescale 1ns/1ps

module alloc_gather_top #(
    parameter int CONTEXTS = 2,
    parameter int Q_DEPTH  = 4
) (
    input  logic                     clk,
    input  logic                     srst,
    input  logic                     en,
    input  gather_pkg::gather_req_t  gather_req [CONTEXTS],
    output logic [CONTEXTS-1:0]      gather_rdy,
    output gather_pkg::gather_resp_t gather_resp [CONTEXTS],
    input  logic [CONTEXTS-1:0]      gather_ack,
    input  gather_pkg::desc_wr_t     desc_wr,
    output logic                     dealloc_req,
    input  logic                     dealloc_rdy,
    output alloc_pkg::ptr_t          dealloc_ptr
);

    // One entry per pointer value
    localparam int MEM_DEPTH = 2 ** alloc_pkg::PTR_WID;

    logic             rd_req;
    logic             rd_rdy;
    alloc_pkg::ptr_t  rd_addr;
    logic             rd_ack;
    alloc_pkg::desc_t rd_data;
    logic             init_done;

    alloc_gather_core #(
        .CONTEXTS (CONTEXTS),
        .Q_DEPTH  (Q_DEPTH)
    ) u_core (
        .clk         (clk),
        .srst        (srst),
        .en          (en),
        .gather_req  (gather_req),
        .gather_rdy  (gather_rdy),
        .gather_resp (gather_resp),
        .gather_ack  (gather_ack),
        .dealloc_req (dealloc_req),
        .dealloc_rdy (dealloc_rdy),
        .dealloc_ptr (dealloc_ptr),
        .rd_req      (rd_req),
        .rd_rdy      (rd_rdy),
        .rd_addr     (rd_addr),
        .rd_ack      (rd_ack),
        .rd_data     (rd_data),
        .init_done   (init_done)
    );

    desc_mem #(
        .DEPTH (MEM_DEPTH)
    ) u_desc_mem (
        .clk       (clk),
        .srst      (srst),
        .wr        (desc_wr),
        .rd_req    (rd_req),
        .rd_rdy    (rd_rdy),
        .rd_addr   (rd_addr),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .init_done (init_done)
    );

endmodule : alloc_gather_top

// ==== bench/alloc_gather_tb.sv ====
`timescale 1ns/1ps

module alloc_gather_tb;

    localparam int CONTEXTS = 2;
    localparam int N_CMDS   = 128;
    localparam int WAIT_MAX = 3000;

    logic                     clk;
    logic                     srst;
    logic                     en;
    gather_pkg::gather_req_t  gather_req [CONTEXTS];
    logic [CONTEXTS-1:0]      gather_rdy;
    gather_pkg::gather_resp_t gather_resp [CONTEXTS];
    logic [CONTEXTS-1:0]      gather_ack;
    gather_pkg::desc_wr_t     desc_wr;
    logic                     dealloc_req;
    logic                     dealloc_rdy;
    alloc_pkg::ptr_t          dealloc_ptr;

    // Command words from the data file
    logic [31:0] cmds [N_CMDS];
    // Reference descriptor table, raw 20-bit words
    logic [19:0] table_copy [64];

    // Expected chain per context, with response and dealloc progress
    logic [5:0]          exp_ptr [CONTEXTS][64];
    int                  exp_cnt [CONTEXTS];
    int                  rsp_cnt [CONTEXTS];
    int                  dl_cnt [CONTEXTS];
    logic [CONTEXTS-1:0] in_chain;
    logic [CONTEXTS-1:0] accepted;

    int     ack_stall;
    int     dl_stall;
    int     ack_gap [CONTEXTS];
    int     dl_gap;
    integer seed;
    int     err_cnt;
    int     test_err;
    int     tests_run;
    int     tests_bad;
    bit     aborted;

    alloc_gather_top #(
        .CONTEXTS (CONTEXTS),
        .Q_DEPTH  (4)
    ) u_alloc_gather_top (
        .clk         (clk),
        .srst        (srst),
        .en          (en),
        .gather_req  (gather_req),
        .gather_rdy  (gather_rdy),
        .gather_resp (gather_resp),
        .gather_ack  (gather_ack),
        .desc_wr     (desc_wr),
        .dealloc_req (dealloc_req),
        .dealloc_rdy (dealloc_rdy),
        .dealloc_ptr (dealloc_ptr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model and checks
    // ----------------------------------------
    task automatic note_error();
        err_cnt++;
        test_err++;
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s at %0t ns", what, $time);
            note_error();
        end
    endtask

    task automatic check_value(input string name, input logic [19:0] got,
                               input logic [19:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
            note_error();
        end
    endtask

    // Read address, then eof, size, meta and err of the descriptor
    function automatic logic [19:0] expected_info(input logic [5:0] ptr);
        logic [19:0] d;
        d = table_copy[ptr];
        return {ptr, d[13], d[12:5], d[4:1], d[0]};
    endfunction

    // Follow next pointers from the head until eof
    task automatic walk_chain(input int c, input logic [5:0] head);
        logic [5:0] p;
        bit         last;
        p          = head;
        last       = 1'b0;
        exp_cnt[c] = 0;
        rsp_cnt[c] = 0;
        dl_cnt[c]  = 0;
        while (!last && exp_cnt[c] < 64) begin
            exp_ptr[c][exp_cnt[c]] = p;
            exp_cnt[c]++;
            last = table_copy[p][13];
            p    = table_copy[p][19:14];
        end
    endtask

    function automatic bit chains_done();
        bit done;
        done = 1'b1;
        for (int c = 0; c < CONTEXTS; c++) begin
            if (rsp_cnt[c] != exp_cnt[c] || dl_cnt[c] != exp_cnt[c] || gather_req[c].vld) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    // ----------------------------------------
    // One clock cycle, from falling edge to falling edge
    // ----------------------------------------
    task automatic run_cycle();
        bit         hit;
        logic [5:0] nxt [CONTEXTS];
        for (int c = 0; c < CONTEXTS; c++) begin
            if (ack_gap[c] > 0) begin
                gather_ack[c] = 1'b0;
                ack_gap[c]--;
            end else begin
                gather_ack[c] = 1'b1;
                if (ack_stall > 0) begin
                    ack_gap[c] = $unsigned($random(seed)) % (ack_stall + 1);
                end
            end
        end
        if (dl_gap > 0) begin
            dealloc_rdy = 1'b0;
            dl_gap--;
        end else begin
            dealloc_rdy = 1'b1;
            if (dl_stall > 0) begin
                dl_gap = $unsigned($random(seed)) % (dl_stall + 1);
            end
        end

        for (int c = 0; c < CONTEXTS; c++) begin
            // Ready may rise early only while the eof entry is still queued
            check_true(!(in_chain[c] && gather_rdy[c]) || gather_resp[c].vld,
                       $sformatf("gather_rdy[%0d] high before the end of its chain", c));
            if (gather_resp[c].vld && gather_ack[c]) begin
                if (rsp_cnt[c] < exp_cnt[c]) begin
                    check_value($sformatf("gather_resp[%0d].info", c), gather_resp[c].info,
                                expected_info(exp_ptr[c][rsp_cnt[c]]));
                    rsp_cnt[c]++;
                    if (rsp_cnt[c] == exp_cnt[c]) begin
                        in_chain[c] = 1'b0;
                    end
                end else begin
                    check_true(1'b0, $sformatf("unexpected response on context %0d", c));
                end
            end
            if (gather_req[c].vld && gather_rdy[c]) begin
                accepted[c] = 1'b1;
                in_chain[c] = 1'b1;
            end
        end

        // Pointers of different chains interleave, each chain stays in order
        if (dealloc_req && dealloc_rdy) begin
            hit = 1'b0;
            for (int c = 0; c < CONTEXTS; c++) begin
                nxt[c] = (dl_cnt[c] < exp_cnt[c]) ? exp_ptr[c][dl_cnt[c]] : 'x;
                if (!hit && dl_cnt[c] < exp_cnt[c] && nxt[c] == dealloc_ptr) begin
                    hit = 1'b1;
                    dl_cnt[c]++;
                end
            end
            assert (hit) else begin
                $display("mismatch at %0t ns: dealloc_ptr expected %h or %h got %h",
                         $time, nxt[0], nxt[1], dealloc_ptr);
                note_error();
            end
        end

        @(negedge clk);
        desc_wr.vld = 1'b0;
        for (int c = 0; c < CONTEXTS; c++) begin
            if (accepted[c]) begin
                gather_req[c].vld = 1'b0;
                accepted[c]       = 1'b0;
            end
        end
    endtask

    task automatic finish_test(input int num);
        int n;
        n = 0;
        while (!chains_done() && n < WAIT_MAX) begin
            run_cycle();
            n++;
        end
        check_true(chains_done(), $sformatf("timeout waiting for test %0d to finish", num));
        if (!chains_done()) begin
            aborted = 1'b1;
        end else begin
            for (int c = 0; c < CONTEXTS; c++) begin
                check_true(gather_rdy[c], $sformatf("gather_rdy[%0d] low after eof", c));
            end
        end
        tests_run++;
        if (test_err != 0) begin
            tests_bad++;
        end
        $display("test %0d: %s, %0d errors", num, (test_err == 0) ? "ok" : "failed", test_err);
        test_err = 0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int          pc;
        int          n;
        int          c;
        logic [31:0] w;
        seed        = 32'ha060_9d7a;
        srst        = 1'b1;
        en          = 1'b1;
        gather_ack  = '0;
        dealloc_rdy = 1'b0;
        desc_wr     = '0;
        in_chain    = '0;
        accepted    = '0;
        ack_stall   = 0;
        dl_stall    = 0;
        dl_gap      = 0;
        err_cnt     = 0;
        test_err    = 0;
        tests_run   = 0;
        tests_bad   = 0;
        aborted     = 1'b0;
        for (int i = 0; i < CONTEXTS; i++) begin
            gather_req[i] = '0;
            exp_cnt[i]    = 0;
            rsp_cnt[i]    = 0;
            dl_cnt[i]     = 0;
            ack_gap[i]    = 0;
        end
        // Matches the cleared memory after the init sweep
        for (int i = 0; i < 64; i++) begin
            table_copy[i] = '0;
        end
        for (int i = 0; i < N_CMDS; i++) begin
            cmds[i] = '0;
        end
        $readmemh("bench/alloc_gather_testdata.txt", cmds);

        repeat (8) @(negedge clk);
        srst = 1'b0;
        n = 0;
        while (!(&gather_rdy) && n < 200) begin
            @(negedge clk);
            n++;
        end
        check_true(&gather_rdy, "timeout waiting for gather_rdy after reset");
        aborted = !(&gather_rdy);

        pc = 0;
        while (!aborted && pc < N_CMDS && cmds[pc][31:28] != 4'h0) begin
            w = cmds[pc];
            pc++;
            case (w[31:28])
                4'h1: begin
                    desc_wr.vld  = 1'b1;
                    desc_wr.addr = w[25:20];
                    desc_wr.desc = w[19:0];
                    table_copy[w[25:20]] = w[19:0];
                    run_cycle();
                end
                4'h2: begin
                    c = int'(w[11:8]);
                    walk_chain(c, w[5:0]);
                    gather_req[c].ptr = w[5:0];
                    gather_req[c].vld = 1'b1;
                end
                4'h3: en = w[0];
                4'h4: ack_stall = int'(w[15:0]);
                4'h5: dl_stall = int'(w[15:0]);
                4'h6: finish_test(int'(w[7:0]));
                4'h7: begin
                    for (int i = 0; i < int'(w[15:0]); i++) begin
                        check_true(!gather_resp[0].vld && !gather_resp[1].vld && !dealloc_req,
                                   "response or deallocation while disabled");
                        run_cycle();
                    end
                end
                default: check_true(1'b0, $sformatf("unknown command word %h", w));
            endcase
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_bad, err_cnt);
        if (err_cnt == 0 && !aborted && tests_run > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : alloc_gather_tb

// ==== bench/alloc_gather_testdata.txt ====
// op[31:28] 1=desc write (addr[25:20], desc[19:0]) 2=start (ctx[11:8], head[7:0])
// 3=en[0] 4=ack stall 5=dealloc stall 6=end test (num[7:0]) 7=quiet cycles
10548806
11281015
120EA38A
10824202
10929FFF
10A2C020
10B0266F
130C4884
131FCFD8
13F02013
// single chain on context 0
20000005
60000001
// both contexts together
20000008
20000130
60000002
// dealloc order with short dealloc gaps
50000003
20000030
20000105
60000003
// long ack and dealloc stalls
4000000C
5000000F
20000008
20000105
60000004
// ready stays low during the chain
40000006
50000000
20000108
60000005
// disabled core stays quiet
40000000
30000000
20000030
70000028
30000001
60000006

// ==== src.f ====
verilog/alloc_pkg.sv
verilog/gather_pkg.sv
verilog/fifo_ctxt.sv
verilog/arb_rr.sv
verilog/desc_mem.sv
verilog/alloc_gather_core.sv
verilog/alloc_gather_top.sv
bench/alloc_gather_tb.sv

// ==== Bender.yml ====
package:
  name: alloc_gather

sources:
  - verilog/alloc_pkg.sv
  - verilog/gather_pkg.sv
  - verilog/fifo_ctxt.sv
  - verilog/arb_rr.sv
  - verilog/desc_mem.sv
  - verilog/alloc_gather_core.sv
  - verilog/alloc_gather_top.sv
  - target: test
    files:
      - bench/alloc_gather_tb.sv
